// File: hdl/alu_pkg.sv
/* Shared ALU definitions: datapath and lane widths, operator codes,
   request and response structs */
package alu_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int XLEN     = 32;
    localparam int SHAMT_W  = 5;

    // Polar SIMD lanes
    localparam int LANE_W   = 8;
    localparam int LANES    = 4;
    localparam int LANE_SAT = 127;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [LANE_W-1:0] lane_t;

    // --------------------------------------------------
    // Operators
    // --------------------------------------------------
    typedef enum logic [4:0] {
        // Adder
        op_add,
        op_sub,
        // Bitwise logic
        op_and,
        op_or,
        op_xor,
        op_andn,
        op_orn,
        op_xnor,
        // Shifts
        op_sll,
        op_srl,
        op_sra,
        // Set less than
        op_slts,
        op_sltu,
        // Branch compares
        op_eq,
        op_ne,
        op_lts,
        op_ltu,
        op_ges,
        op_geu,
        // Polar extension
        op_pl_r,
        op_pl_f,
        op_pl_decode,
        op_pl_g
    } alu_op_e;

    // --------------------------------------------------
    // Request and response
    // --------------------------------------------------
    typedef struct packed {
        alu_op_e op;
        xlen_t   operand_a;
        xlen_t   operand_b;
        xlen_t   imm;
    } alu_req_t;

    typedef struct packed {
        xlen_t result;
        logic  branch;
    } alu_rsp_t;

endpackage

// File: hdl/alu_int_unit.sv
/* Integer unit: shared adder, logic ops, shifter, comparator
   and branch resolution */
module alu_int_unit (
    input  alu_pkg::alu_req_t req_i,
    output alu_pkg::alu_rsp_t int_rsp_o
);
    import alu_pkg::*;

    // Mirror the bit order of a word
    function automatic xlen_t bit_reverse(input xlen_t value);
        xlen_t reversed;
        for (int k = 0; k < XLEN; k++) begin
            reversed[k] = value[XLEN-1-k];
        end
        return reversed;
    endfunction

    // --------------------------------------------------
    // Adder
    // --------------------------------------------------
    logic          negate_b;
    logic [XLEN:0] adder_in_a;
    logic [XLEN:0] operand_b_neg;
    logic [XLEN:0] adder_sum;
    xlen_t         adder_result;
    xlen_t         logic_b;
    logic          adder_zero;

    always_comb begin
        case (req_i.op)
            op_sub, op_eq, op_ne,
            op_andn, op_orn, op_xnor: negate_b = 1'b1;
            default:                  negate_b = 1'b0;
        endcase
    end

    // Extra low bit pair injects the carry when b is inverted
    assign adder_in_a    = {req_i.operand_a, 1'b1};
    assign operand_b_neg = {req_i.operand_b, 1'b0} ^ {(XLEN+1){negate_b}};
    assign adder_sum     = adder_in_a + operand_b_neg;
    assign adder_result  = adder_sum[XLEN:1];
    assign adder_zero    = ~|adder_result;

    // Logic ops see the same optionally inverted b
    assign logic_b       = operand_b_neg[XLEN:1];

    // --------------------------------------------------
    // Shifter
    // --------------------------------------------------
    logic               shift_left;
    logic               shift_arith;
    logic [SHAMT_W-1:0] shift_amt;
    xlen_t              shift_op_a;
    logic [XLEN:0]      shift_right_ext;
    xlen_t              shift_right_result;
    xlen_t              shift_result;

    assign shift_left  = (req_i.op == op_sll);
    assign shift_arith = (req_i.op == op_sra);
    assign shift_amt   = req_i.operand_b[SHAMT_W-1:0];

    // Left shift is a right shift on the reversed word
    assign shift_op_a  = shift_left ? bit_reverse(req_i.operand_a) : req_i.operand_a;

    assign shift_right_ext = $unsigned(
        $signed({shift_arith & shift_op_a[XLEN-1], shift_op_a}) >>> shift_amt);
    assign shift_right_result = shift_right_ext[XLEN-1:0];
    assign shift_result = shift_left ? bit_reverse(shift_right_result) : shift_right_result;

    // --------------------------------------------------
    // Comparator
    // --------------------------------------------------
    logic signed_cmp;
    logic less;

    assign signed_cmp = (req_i.op == op_slts) || (req_i.op == op_lts) ||
                        (req_i.op == op_ges);

    // One extra top bit selects signed or unsigned order
    assign less = $signed({signed_cmp & req_i.operand_a[XLEN-1], req_i.operand_a}) <
                  $signed({signed_cmp & req_i.operand_b[XLEN-1], req_i.operand_b});

    // Branch resolution
    always_comb begin
        case (req_i.op)
            op_eq:          int_rsp_o.branch = adder_zero;
            op_ne:          int_rsp_o.branch = ~adder_zero;
            op_lts, op_ltu: int_rsp_o.branch = less;
            op_ges, op_geu: int_rsp_o.branch = ~less;
            default:        int_rsp_o.branch = 1'b1;
        endcase
    end

    // --------------------------------------------------
    // Result mux
    // --------------------------------------------------
    always_comb begin
        case (req_i.op)
            op_add, op_sub:          int_rsp_o.result = adder_result;
            op_and, op_andn:         int_rsp_o.result = req_i.operand_a & logic_b;
            op_or, op_orn:           int_rsp_o.result = req_i.operand_a | logic_b;
            op_xor, op_xnor:         int_rsp_o.result = req_i.operand_a ^ logic_b;
            op_sll, op_srl, op_sra:  int_rsp_o.result = shift_result;
            op_slts, op_sltu:        int_rsp_o.result = {{(XLEN-1){1'b0}}, less};
            // Branches return the adder output
            op_eq, op_ne,
            op_lts, op_ltu,
            op_ges, op_geu:          int_rsp_o.result = adder_result;
            default:                 int_rsp_o.result = '0;
        endcase
    end

endmodule

// File: hdl/alu_polar_unit.sv
/* Polar SIMD unit: R, F, DECODE and saturating G over four signed
   8-bit lanes */
module alu_polar_unit (
    input  alu_pkg::alu_req_t req_i,
    output alu_pkg::xlen_t    polar_result_o
);
    import alu_pkg::*;

    // Clamp a 9-bit lane value to the symmetric range
    function automatic lane_t saturate(input logic signed [LANE_W:0] value);
        lane_t clamped;
        if (value > LANE_SAT) begin
            clamped = lane_t'(LANE_SAT);
        end else if (value < -LANE_SAT) begin
            clamped = lane_t'(-LANE_SAT);
        end else begin
            clamped = value[LANE_W-1:0];
        end
        return clamped;
    endfunction

    xlen_t func_r;
    xlen_t func_f;
    xlen_t func_decode;
    xlen_t func_g;
    logic  b_is_one;
    logic  b_is_zero;

    // Low byte of operand_b acts as a control word for R and DECODE
    assign b_is_one  = (req_i.operand_b[LANE_W-1:0] == lane_t'(1));
    assign b_is_zero = (req_i.operand_b[LANE_W-1:0] == lane_t'(0));

    // --------------------------------------------------
    // Per lane datapath
    // --------------------------------------------------
    for (genvar i = 0; i < LANES; i++) begin : gen_lane
        lane_t                  lane_a;
        lane_t                  lane_b;
        lane_t                  lane_imm;
        lane_t                  abs_a;
        lane_t                  abs_b;
        lane_t                  min_mag;
        logic                   sign_diff;
        logic signed [LANE_W:0] sum;
        logic signed [LANE_W:0] diff;

        assign lane_a   = req_i.operand_a[i*LANE_W +: LANE_W];
        assign lane_b   = req_i.operand_b[i*LANE_W +: LANE_W];
        assign lane_imm = req_i.imm[i*LANE_W +: LANE_W];

        // R flags negative lanes
        assign func_r[i*LANE_W +: LANE_W] =
            (!b_is_one && lane_a[LANE_W-1]) ? lane_t'(1) : lane_t'(0);

        // F keeps the smaller magnitude with the product sign
        // -128 stays 0x80 and compares as magnitude 128
        assign abs_a     = lane_a[LANE_W-1] ? -lane_a : lane_a;
        assign abs_b     = lane_b[LANE_W-1] ? -lane_b : lane_b;
        assign min_mag   = (abs_a > abs_b) ? abs_b : abs_a;
        assign sign_diff = lane_a[LANE_W-1] ^ lane_b[LANE_W-1];
        assign func_f[i*LANE_W +: LANE_W] = sign_diff ? -min_mag : min_mag;

        // DECODE passes a through when enabled
        assign func_decode[i*LANE_W +: LANE_W] = b_is_zero ? lane_a : lane_t'(0);

        // G adds or subtracts one bit wider before clamping
        assign sum  = $signed({lane_a[LANE_W-1], lane_a}) + $signed({lane_b[LANE_W-1], lane_b});
        assign diff = $signed({lane_b[LANE_W-1], lane_b}) - $signed({lane_a[LANE_W-1], lane_a});
        assign func_g[i*LANE_W +: LANE_W] =
            (lane_imm == lane_t'(0)) ? saturate(sum) : saturate(diff);
    end

    // --------------------------------------------------
    // Output select
    // --------------------------------------------------
    always_comb begin
        case (req_i.op)
            op_pl_r:      polar_result_o = func_r;
            op_pl_f:      polar_result_o = func_f;
            op_pl_decode: polar_result_o = func_decode;
            op_pl_g:      polar_result_o = func_g;
            default:      polar_result_o = '0;
        endcase
    end

endmodule

// File: hdl/alu_writeback.sv
/* Writeback stage: result select by operator class and the
   registered response with valid */
module alu_writeback (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              valid_i,
    input  alu_pkg::alu_op_e  op_i,
    input  alu_pkg::alu_rsp_t int_rsp_i,
    input  alu_pkg::xlen_t    polar_result_i,
    output logic              valid_o,
    output alu_pkg::alu_rsp_t rsp_o
);
    import alu_pkg::*;

    logic     is_polar;
    alu_rsp_t rsp_next;

    always_comb begin
        case (op_i)
            op_pl_r, op_pl_f,
            op_pl_decode, op_pl_g: is_polar = 1'b1;
            default:               is_polar = 1'b0;
        endcase
    end

    // Polar ops always report a taken branch flag
    always_comb begin
        if (is_polar) begin
            rsp_next.result = polar_result_i;
            rsp_next.branch = 1'b1;
        end else begin
            rsp_next = int_rsp_i;
        end
    end

    // Output register, holds its value across idle cycles
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            rsp_o   <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                rsp_o <= rsp_next;
            end
        end
    end

endmodule

// File: hdl/alu_top.sv
/* ALU top level: integer and polar units in parallel,
   followed by the writeback register */
module alu_top (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              valid_i,
    input  alu_pkg::alu_req_t req_i,
    output logic              valid_o,
    output alu_pkg::alu_rsp_t rsp_o
);
    import alu_pkg::*;

    alu_rsp_t int_rsp;
    xlen_t    polar_result;

    // Both units see the same request
    alu_int_unit alu_int_unit_i (
        .req_i     (req_i),
        .int_rsp_o (int_rsp)
    );

    alu_polar_unit alu_polar_unit_i (
        .req_i          (req_i),
        .polar_result_o (polar_result)
    );

    alu_writeback alu_writeback_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .op_i           (req_i.op),
        .int_rsp_i      (int_rsp),
        .polar_result_i (polar_result),
        .valid_o        (valid_o),
        .rsp_o          (rsp_o)
    );

endmodule

// File: testbench/tb_clock_gen.sv
/* Clock and reset generation for the ALU testbench */
module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

    // Reset released on a rising edge, like any other driven input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// File: testbench/tb_alu_checker.sv
/* Response checker: queues expected responses and compares them
   with the registered DUT outputs */
module tb_alu_checker (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              exp_push_i,
    input  alu_pkg::alu_rsp_t exp_rsp_i,
    input  logic              dut_valid_i,
    input  alu_pkg::alu_rsp_t dut_rsp_i,
    input  logic              end_of_test_i,
    output int                checked_o,
    output int                mismatches_o,
    output int                protocol_errors_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import alu_pkg::*;

    alu_rsp_t expected_q[$];
    logic     in_reset_q  = 1'b1;
    logic     end_checked = 1'b0;
    int       checked         = 0;
    int       mismatches      = 0;
    int       protocol_errors = 0;

    assign checked_o         = checked;
    assign mismatches_o      = mismatches;
    assign protocol_errors_o = protocol_errors;

    task automatic compare_rsp(input alu_rsp_t exp_rsp, input alu_rsp_t act_rsp);
        if (act_rsp.result !== exp_rsp.result) begin
            mismatches++;
            $display("ERROR at %0d ns: rsp_o.result expected %h actual %h",
                     $time, exp_rsp.result, act_rsp.result);
        end
        if (act_rsp.branch !== exp_rsp.branch) begin
            mismatches++;
            $display("ERROR at %0d ns: rsp_o.branch expected %b actual %b",
                     $time, exp_rsp.branch, act_rsp.branch);
        end
        checked++;
    endtask

    // --------------------------------------------------
    // Sampling on every rising edge
    // --------------------------------------------------
    always @(posedge clk_i) begin
        if (reset_i) begin
            if (dut_valid_i === 1'b1) begin
                protocol_errors++;
                $display("ERROR at %0d ns: valid_o expected 0 actual 1", $time);
            end
            in_reset_q = 1'b1;
        end else begin
            // First edge after reset shows the cleared register
            if (in_reset_q) begin
                if (dut_valid_i !== 1'b0 || dut_rsp_i !== '0) begin
                    protocol_errors++;
                    $display("ERROR at %0d ns: valid_o,rsp_o expected 0,%h actual %b,%h",
                             $time, 33'h0, dut_valid_i, dut_rsp_i);
                end
            end
            in_reset_q = 1'b0;

            // Pop before push
            // A request taken at this edge shows on the next one
            if (dut_valid_i === 1'b1) begin
                if (expected_q.size() == 0) begin
                    protocol_errors++;
                    $display("valid_o went high at %0d ns with no request outstanding",
                             $time);
                end else begin
                    compare_rsp(expected_q.pop_front(), dut_rsp_i);
                end
            end else if (expected_q.size() != 0) begin
                protocol_errors++;
                $display("valid_o stayed low at %0d ns one cycle after a valid request",
                         $time);
            end
            if (exp_push_i) begin
                expected_q.push_back(exp_rsp_i);
            end

            if (end_of_test_i && !end_checked) begin
                end_checked = 1'b1;
                if (expected_q.size() != 0) begin
                    protocol_errors++;
                    $display("%0d expected responses never appeared on the output",
                             expected_q.size());
                end
            end
        end
    end

endmodule

// File: testbench/tb_alu.sv
/* ALU testbench top: golden-file reader, stimulus driver,
   watchdog and final verdict */
module tb_alu;
    timeunit 1ns;
    timeprecision 1ps;
    import alu_pkg::*;

    localparam int    PERIOD_NS   = 4;
    localparam string GOLDEN_FILE = "testbench/alu_golden.txt";

    // Parsed golden line
    // The idle flag marks a cycle with valid_i low
    typedef struct packed {
        logic     idle;
        alu_req_t req;
        alu_rsp_t rsp;
    } vector_t;

    logic     clk;
    logic     reset;
    logic     valid;
    alu_req_t req;
    logic     valid_out;
    alu_rsp_t rsp_out;
    logic     exp_push;
    alu_rsp_t exp_rsp;
    logic     end_of_test;
    logic     load_done;
    int       checked;
    int       mismatches;
    int       protocol_errors;
    int       load_errors;
    int       expected_count;
    vector_t  vectors[$];

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (3)
    ) clock_gen_i (
        .clk_o   (clk),
        .reset_o (reset)
    );

    alu_top alu_top_i (
        .clk_i   (clk),
        .reset_i (reset),
        .valid_i (valid),
        .req_i   (req),
        .valid_o (valid_out),
        .rsp_o   (rsp_out)
    );

    tb_alu_checker response_checker_i (
        .clk_i             (clk),
        .reset_i           (reset),
        .exp_push_i        (exp_push),
        .exp_rsp_i         (exp_rsp),
        .dut_valid_i       (valid_out),
        .dut_rsp_i         (rsp_out),
        .end_of_test_i     (end_of_test),
        .checked_o         (checked),
        .mismatches_o      (mismatches),
        .protocol_errors_o (protocol_errors)
    );

    // --------------------------------------------------
    // Golden file reader
    // --------------------------------------------------
    task automatic load_vectors();
        int         fd;
        int         fields;
        int         line_no;
        string      line;
        logic [4:0] op_code;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm;
        xlen_t      result;
        logic       branch;
        vector_t    vec;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN_FILE);
            load_errors++;
            return;
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            vec = '0;
            if (line.substr(0, 3) == "idle") begin
                vec.idle = 1'b1;
            end else begin
                fields = $sscanf(line, "%h %h %h %h %h %h", op_code, a, b, imm, result, branch);
                if (fields != 6) begin
                    $display("Line %0d of %s could not be parsed", line_no, GOLDEN_FILE);
                    load_errors++;
                    continue;
                end
                vec.req = '{alu_op_e'(op_code), a, b, imm};
                vec.rsp = '{result, branch};
                expected_count++;
            end
            vectors.push_back(vec);
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input vector_t vec);
        if (vec.idle) begin
            valid    <= 1'b0;
            exp_push <= 1'b0;
        end else begin
            valid    <= 1'b1;
            req      <= vec.req;
            exp_push <= 1'b1;
            exp_rsp  <= vec.rsp;
        end
    endtask

    // --------------------------------------------------
    // Stimulus and verdict
    // --------------------------------------------------
    initial begin : stimulus
        // Request held high through reset so valid_o must stay cleared
        valid          = 1'b1;
        req            = '0;
        exp_push       = 1'b0;
        exp_rsp        = '0;
        end_of_test    = 1'b0;
        load_done      = 1'b0;
        load_errors    = 0;
        expected_count = 0;
        load_vectors();
        if (load_errors != 0 || vectors.size() == 0) begin
            $display("No usable vectors, %0d problems in the golden file", load_errors);
            $display("Simulation failed");
            $finish;
        end else begin
            load_done = 1'b1;
            @(negedge reset);
            // Drop the reset-time request before the first vector
            valid <= 1'b0;
            foreach (vectors[i]) begin
                @(posedge clk);
                drive_vector(vectors[i]);
            end
            @(posedge clk);
            valid    <= 1'b0;
            exp_push <= 1'b0;
            repeat (3) @(posedge clk);
            end_of_test <= 1'b1;
            repeat (2) @(posedge clk);
            $display("Checked %0d of %0d responses, %0d mismatches, %0d protocol errors",
                     checked, expected_count, mismatches, protocol_errors);
            if (mismatches == 0 && protocol_errors == 0 && checked == expected_count) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // Two clock periods per vector plus margin for reset and drain
    initial begin : watchdog
        int limit_ns;
        wait (load_done);
        limit_ns = vectors.size() * PERIOD_NS * 2 + 100;
        #(limit_ns);
        $display("Watchdog expired after %0d ns before all responses were checked", limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: testbench/alu_golden.txt
# op a b imm result branch, all hex, op is the alu_op_e code
# a line reading idle holds valid_i low for one cycle
00 7fffffff 00000001 00000000 80000000 1
00 ffffffff 00000002 00000000 00000001 1
01 00000000 00000001 00000000 ffffffff 1
02 f0f0f0f0 3c3c3c3c 00000000 30303030 1
03 f0f0f0f0 0f0f0000 00000000 fffff0f0 1
04 aaaa5555 ffff0000 00000000 55555555 1
05 ffff00ff 0f0f0f0f 00000000 f0f000f0 1
06 00000000 ffff0000 00000000 0000ffff 1
07 12345678 12345678 00000000 ffffffff 1
idle
08 00000001 00000024 00000000 00000010 1
08 80000001 0000001f 00000000 80000000 1
09 80000000 00000004 00000000 08000000 1
09 f0000000 ffffffe1 00000000 78000000 1
0a 80000000 00000004 00000000 f8000000 1
0a 7ffffff0 0000001f 00000000 00000000 1
0b ffffffff 00000001 00000000 00000001 1
0c ffffffff 00000001 00000000 00000000 1
0d deadbeef deadbeef 00000000 00000000 1
0d 00000001 00000002 00000000 ffffffff 0
0e 00000001 00000002 00000000 ffffffff 1
idle
idle
0f 80000000 00000001 00000000 80000001 1
10 80000000 00000001 00000000 80000001 0
11 80000000 00000001 00000000 80000001 0
12 80000000 00000001 00000000 80000001 1
0f 00000003 00000003 00000000 00000006 0
13 807f00ff 00000000 00000000 01000001 1
13 807f00ff 00000001 00000000 00000000 1
14 8005fb10 7ffd0520 00000000 81fdfb10 1
14 8080f60a 8001f60a 00000000 80ff0a0a 1
15 11223344 00000100 00000000 11223344 1
15 11223344 00000002 00000000 00000000 1
16 709040c0 20e03fc1 00000000 7f817f81 1
16 80107f05 7f208003 01000100 7f308108 1
16 80000000 80000000 00000000 81000000 1
16 01020304 04040404 ffffffff 03020100 1

// File: sim.f
hdl/alu_pkg.sv
hdl/alu_int_unit.sv
hdl/alu_polar_unit.sv
hdl/alu_writeback.sv
hdl/alu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_alu_checker.sv
testbench/tb_alu.sv

// File: Makefile
# Verilator build and run of the ALU testbench

VERILATOR ?= verilator
TOP       ?= tb_alu
RTL_TOP   ?= alu_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only
PASS_MSG  ?= Simulation passed

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(shell grep '^hdl/' $(FILELIST))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
